/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // One opcode byte seen as the raw value or as the aaa/bbb/cc fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] aaa;
            logic [2:0] bbb;                // Addressing field
            logic [1:0] cc;                 // Instruction group
        } f;
    } opcode_t;

    typedef enum logic [2:0] {
        ADR_IMM,
        ADR_ZPG,
        ADR_ZPG_X,
        ADR_ABS,
        ADR_ACC,
        ADR_IMPL
    } addr_mode_e;

    typedef enum logic [1:0] {
        ALU_NOP,
        ALU_ASL,
        ALU_ADD,                            // Zero-page base plus X
        ALU_PASS
    } alu_op_e;

    typedef enum logic [1:0] {
        ADDR_PC,
        ADDR_LATCH,
        ADDR_STACK
    } addr_sel_e;

    typedef enum logic [1:0] {
        DBUF_A,
        DBUF_IDL,
        DBUF_STATUS
    } dbuf_sel_e;

    typedef struct packed {
        logic n;
        logic v;
        logic unused;
        logic b;
        logic d;
        logic i;
        logic z;
        logic c;
    } status_t;

    // Control word from the decoder to the datapath
    typedef struct packed {
        alu_op_e   alu_op;
        logic      a_load;
        logic      x_load;
        logic      sp_dec;
        logic      flags_we;                // Update c, z and n from the ALU
        logic      adl_load;
        logic      adh_load;
        logic      adl_from_alu;
        logic      idl_load;
        logic      idl_from_alu;
        dbuf_sel_e dbuf_sel;
        addr_sel_e addr_sel;
        logic      rw;                      // High for read
        logic      pc_inc;
    } ctl_t;

    localparam logic [7:0] OP_ASL_A     = 8'h0A;
    localparam logic [7:0] OP_ASL_ZPG   = 8'h06;
    localparam logic [7:0] OP_ASL_ZPG_X = 8'h16;
    localparam logic [7:0] OP_ASL_ABS   = 8'h0E;
    localparam logic [7:0] OP_LDA_IMM   = 8'hA9;
    localparam logic [7:0] OP_LDX_IMM   = 8'hA2;
    localparam logic [7:0] OP_STA_ZPG   = 8'h85;
    localparam logic [7:0] OP_PHP       = 8'h08;
    localparam logic [7:0] OP_NOP       = 8'hEA;

endpackage

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_e alu_op,
    input  wire [7:0]             a_in,
    input  wire [7:0]             b_in,
    output logic [7:0]            result,
    output logic                  carry,
    output logic                  zero,
    output logic                  negative
);
    import cpu_pkg::*;

    always_comb begin
        case (alu_op)
            ALU_ASL: begin
                {carry, result} = {a_in, 1'b0};         // Bit 7 goes to carry
            end
            ALU_ADD: begin
                {carry, result} = {1'b0, a_in} + {1'b0, b_in};  // Stays in the page
            end
            ALU_PASS: begin
                {carry, result} = {1'b0, a_in};
            end
            default: begin
                {carry, result} = 9'h000;
            end
        endcase
    end

    assign zero     = (result == 8'h00);
    assign negative = result[7];

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`default_nettype none

module register_file (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              rdy,
    input  wire cpu_pkg::ctl_t ctl,
    input  wire  [7:0]       data_in,
    input  wire  [7:0]       alu_result,
    input  wire              alu_carry,
    input  wire              alu_zero,
    input  wire              alu_negative,
    output logic [7:0]       a_value,
    output logic [7:0]       x_value,
    output logic [7:0]       sp_value,
    output cpu_pkg::status_t status
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_value  <= 8'h00;
            x_value  <= 8'h00;
            sp_value <= 8'hFF;
            status   <= '0;
        end else if (rdy) begin
            if (ctl.a_load) begin
                a_value <= (ctl.alu_op == ALU_ASL) ? alu_result : data_in;
            end
            if (ctl.x_load) begin
                x_value <= data_in;
            end
            if (ctl.sp_dec) begin
                sp_value <= sp_value - 8'd1;    // Stack grows down in page one
            end
            if (ctl.flags_we) begin
                status.c <= alu_carry;
            end
            // Loads pass through the ALU so z and n always come from its result
            if (ctl.flags_we || ctl.a_load || ctl.x_load) begin
                status.z <= alu_zero;
                status.n <= alu_negative;
            end
        end
    end

    a_flags_x_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctl.flags_we && ctl.x_load));

endmodule

`default_nettype wire

/* verilog/address_unit.sv */
`default_nettype none

module address_unit #(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              rdy,
    input  wire cpu_pkg::ctl_t ctl,
    input  wire  [7:0]       data_in,
    input  wire  [7:0]       alu_result,
    input  wire  [7:0]       sp_value,
    input  wire  [7:0]       a_value,
    input  wire cpu_pkg::status_t status,
    output logic [7:0]       adl,
    output logic [15:0]      addr,
    output logic [7:0]       data_out
);
    import cpu_pkg::*;

    logic [15:0] pc;
    logic [7:0]  adh;
    logic [7:0]  idl;
    status_t     pushed;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (rdy && ctl.pc_inc) begin
            pc <= pc + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (ctl.adl_load) begin
                adl <= ctl.adl_from_alu ? alu_result : data_in;
            end
            if (ctl.adh_load) begin
                adh <= data_in;
            end else if (ctl.adl_load && !ctl.adl_from_alu) begin
                adh <= 8'h00;                   // Zero page until a high byte arrives
            end
            if (ctl.idl_load) begin
                idl <= ctl.idl_from_alu ? alu_result : data_in;
            end
        end
    end

    always_comb begin
        case (ctl.addr_sel)
            ADDR_LATCH: addr = {adh, adl};
            ADDR_STACK: addr = {8'h01, sp_value};
            default:    addr = pc;
        endcase
    end

    always_comb begin
        pushed   = status;
        pushed.b = 1'b1;                        // Set in the pushed copy only
        case (ctl.dbuf_sel)
            DBUF_IDL:    data_out = idl;
            DBUF_STATUS: data_out = pushed;
            default:     data_out = a_value;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/instruction_decode.sv */
`default_nettype none

module instruction_decode (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           rdy,
    input  wire  [7:0]    data_in,
    output cpu_pkg::ctl_t ctl
);
    import cpu_pkg::*;

    typedef enum logic [3:0] {
        FETCH,
        OPERAND,
        ADR_LOW,
        ADR_HIGH,
        ADR_INDEX,
        DATA_READ,
        MODIFY,
        WRITE_BACK,
        PUSH
    } state_e;

    state_e     state;
    state_e     state_next;
    opcode_t    opcode;
    addr_mode_e mode;
    addr_mode_e fetched_mode;

    function automatic logic is_supported(opcode_t op);
        case (op.raw)
            OP_ASL_A, OP_ASL_ZPG, OP_ASL_ZPG_X, OP_ASL_ABS,
            OP_LDA_IMM, OP_LDX_IMM, OP_STA_ZPG, OP_PHP: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic addr_mode_e mode_of(opcode_t op);
        addr_mode_e m;
        case (op.f.bbb)
            3'b000: m = (op.f.cc == 2'b10) ? ADR_IMM : ADR_IMPL;
            3'b001: m = ADR_ZPG;
            3'b010: begin
                if (op.f.cc == 2'b01) begin
                    m = ADR_IMM;
                end else if (op.f.cc == 2'b10) begin
                    m = ADR_ACC;
                end else begin
                    m = ADR_IMPL;
                end
            end
            3'b011: m = ADR_ABS;
            3'b101: m = ADR_ZPG_X;
            default: m = ADR_IMPL;
        endcase
        if (!is_supported(op)) begin
            m = ADR_IMPL;                   // NOP and unknown opcodes idle one cycle
        end
        return m;
    endfunction

    always_comb fetched_mode = mode_of(data_in);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= FETCH;
            opcode.raw <= OP_NOP;
            mode       <= ADR_IMPL;
        end else if (rdy) begin
            state <= state_next;
            if (state == FETCH) begin
                opcode.raw <= data_in;
                mode       <= fetched_mode;
            end
        end
    end

    always_comb begin
        ctl        = '0;
        ctl.rw     = 1'b1;
        state_next = state;
        case (state)
            FETCH: begin
                ctl.pc_inc = 1'b1;
                if (fetched_mode inside {ADR_ZPG, ADR_ZPG_X, ADR_ABS}) begin
                    state_next = ADR_LOW;
                end else begin
                    state_next = OPERAND;
                end
            end
            OPERAND: begin
                case (mode)
                    ADR_IMM: begin
                        ctl.pc_inc = 1'b1;
                        ctl.alu_op = ALU_PASS;  // Flags from the loaded byte
                        ctl.a_load = (opcode.raw == OP_LDA_IMM);
                        ctl.x_load = (opcode.raw == OP_LDX_IMM);
                    end
                    ADR_ACC: begin
                        ctl.alu_op   = ALU_ASL;
                        ctl.a_load   = 1'b1;
                        ctl.flags_we = 1'b1;
                    end
                    default: ;
                endcase
                state_next = (opcode.raw == OP_PHP) ? PUSH : FETCH;
            end
            ADR_LOW: begin
                ctl.pc_inc   = 1'b1;
                ctl.adl_load = 1'b1;
                case (mode)
                    ADR_ABS:   state_next = ADR_HIGH;
                    ADR_ZPG_X: state_next = ADR_INDEX;
                    default:   state_next = (opcode.raw == OP_STA_ZPG) ? WRITE_BACK : DATA_READ;
                endcase
            end
            ADR_HIGH: begin
                ctl.pc_inc   = 1'b1;
                ctl.adh_load = 1'b1;
                state_next   = DATA_READ;
            end
            ADR_INDEX: begin
                ctl.alu_op       = ALU_ADD;
                ctl.adl_load     = 1'b1;
                ctl.adl_from_alu = 1'b1;
                ctl.addr_sel     = ADDR_LATCH;  // Dummy read of the unindexed byte
                state_next       = DATA_READ;
            end
            DATA_READ: begin
                ctl.addr_sel = ADDR_LATCH;
                ctl.idl_load = 1'b1;
                state_next   = MODIFY;
            end
            MODIFY: begin
                ctl.alu_op       = ALU_ASL;
                ctl.idl_load     = 1'b1;
                ctl.idl_from_alu = 1'b1;
                ctl.flags_we     = 1'b1;
                ctl.dbuf_sel     = DBUF_IDL;    // Feeds the latch to the shifter
                ctl.addr_sel     = ADDR_LATCH;
                state_next       = WRITE_BACK;
            end
            WRITE_BACK: begin
                ctl.addr_sel = ADDR_LATCH;
                ctl.rw       = 1'b0;
                ctl.dbuf_sel = (opcode.raw == OP_STA_ZPG) ? DBUF_A : DBUF_IDL;
                state_next   = FETCH;
            end
            PUSH: begin
                ctl.addr_sel = ADDR_STACK;
                ctl.rw       = 1'b0;
                ctl.dbuf_sel = DBUF_STATUS;
                ctl.sp_dec   = 1'b1;
                state_next   = FETCH;
            end
            default: state_next = FETCH;
        endcase
    end

    a_write_state: assert property (@(posedge clk) disable iff (!rst_n)
        !ctl.rw |-> state inside {WRITE_BACK, PUSH});

    a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !rdy |=> state == $past(state));

endmodule

`default_nettype wire

/* verilog/cpu_core.sv */
`default_nettype none

module cpu_core #(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         rdy,
    input  wire  [7:0]  data_in,
    output logic [15:0] addr,
    output logic [7:0]  data_out,
    output logic        rw
);
    import cpu_pkg::*;

    ctl_t       ctl;
    status_t    status;
    logic [7:0] a_value;
    logic [7:0] x_value;
    logic [7:0] sp_value;
    logic [7:0] adl;
    logic [7:0] alu_a;
    logic [7:0] alu_b;
    logic [7:0] alu_result;
    logic       alu_carry;
    logic       alu_zero;
    logic       alu_negative;

    assign rw = ctl.rw;

    // ALU operand select
    always_comb begin
        case (ctl.alu_op)
            ALU_ASL: begin
                alu_a = ctl.idl_from_alu ? data_out : a_value;  // data_out holds the latch
                alu_b = 8'h00;
            end
            ALU_ADD: begin
                alu_a = adl;
                alu_b = x_value;
            end
            ALU_PASS: begin
                alu_a = data_in;
                alu_b = 8'h00;
            end
            default: begin
                alu_a = 8'h00;
                alu_b = 8'h00;
            end
        endcase
    end

    instruction_decode u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .rdy     (rdy),
        .data_in (data_in),
        .ctl     (ctl)
    );

    alu u_alu (
        .alu_op   (ctl.alu_op),
        .a_in     (alu_a),
        .b_in     (alu_b),
        .result   (alu_result),
        .carry    (alu_carry),
        .zero     (alu_zero),
        .negative (alu_negative)
    );

    register_file u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .rdy          (rdy),
        .ctl          (ctl),
        .data_in      (data_in),
        .alu_result   (alu_result),
        .alu_carry    (alu_carry),
        .alu_zero     (alu_zero),
        .alu_negative (alu_negative),
        .a_value      (a_value),
        .x_value      (x_value),
        .sp_value     (sp_value),
        .status       (status)
    );

    address_unit #(
        .RESET_PC (RESET_PC)
    ) u_addr (
        .clk        (clk),
        .rst_n      (rst_n),
        .rdy        (rdy),
        .ctl        (ctl),
        .data_in    (data_in),
        .alu_result (alu_result),
        .sp_value   (sp_value),
        .a_value    (a_value),
        .status     (status),
        .adl        (adl),
        .addr       (addr),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

/* test/sim_memory.sv */
`default_nettype none

module sim_memory (
    input  wire         clk,
    input  wire         rdy,
    input  wire  [15:0] addr,
    input  wire         rw,
    input  wire  [7:0]  wdata,
    output logic [7:0]  rdata
);
    logic [7:0] mem [0:65535];

    assign rdata = mem[addr];               // Combinational read

    always @(posedge clk) begin
        if (rdy && !rw) begin
            mem[addr] <= wdata;             // Stalled cycles never write
        end
    end

    task automatic clear();
        for (int i = 0; i < 65536; i++) begin
            mem[16'(i)] = 8'h00;
        end
    endtask

    task automatic write_byte(input logic [15:0] a, input logic [7:0] d);
        mem[a] = d;
    endtask

    function automatic logic [7:0] read_byte(input logic [15:0] a);
        return mem[a];
    endfunction

endmodule

`default_nettype wire

/* test/tb_cpu_core.sv */
`default_nettype none

module tb_cpu_core;
    import cpu_pkg::*;

    localparam logic [15:0] RESET_PC      = 16'h0200;
    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 4;
    localparam int          NUM_VALUES    = 4;
    localparam int          STALL_FACTOR  = 3;      // Up to two stalled cycles per bus cycle
    localparam int          MARGIN_CYCLES = 100;

    // Budgets in rdy-high cycles
    localparam int BUDGET_SHIFT_A = 10;             // LDA, ASL A, STA, PHP
    localparam int BUDGET_ZPG     = 8;              // ASL zpg, PHP
    localparam int BUDGET_ZPG_X   = 8;              // LDX, ASL zpg,X
    localparam int BUDGET_ABS     = 6;
    localparam int BUDGET_FIRST   = 5;              // NOP, STA

    localparam int TOTAL_CYCLES =
        NUM_VALUES * (2 * RESET_CYCLES + (1 + STALL_FACTOR) * BUDGET_SHIFT_A) +
        4 * RESET_CYCLES + BUDGET_ZPG + BUDGET_ZPG_X + BUDGET_ABS + BUDGET_FIRST;

    localparam logic [7:0]  STORE_ZP  = 8'h40;
    localparam logic [7:0]  SHIFT_ZP  = 8'h33;
    localparam logic [7:0]  INDEX_ZP  = 8'hF0;
    localparam logic [15:0] ABS_ADDR  = 16'h0345;
    localparam logic [15:0] PUSH_ADDR = 16'h01FF;   // First push after reset

    logic        clk;
    logic        rst_n;
    logic        rdy;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic [15:0] addr;
    logic        rw;

    int          checks;
    int          errors;
    int          tests;
    int          bus_cycles;
    int          writes;
    logic [15:0] first_addr;
    logic        first_rw;
    logic        held;
    logic [15:0] held_addr;
    logic [7:0]  held_data;
    logic        held_rw;
    logic [7:0]  shift_values [NUM_VALUES];

    cpu_core #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .rdy      (rdy),
        .data_in  (data_in),
        .addr     (addr),
        .data_out (data_out),
        .rw       (rw)
    );

    sim_memory u_mem (
        .clk   (clk),
        .rdy   (rdy),
        .addr  (addr),
        .rw    (rw),
        .wdata (data_out),
        .rdata (data_in)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %02h (n=%b z=%b c=%b b=%b), expected %02h",
                     $time, what, got, got.n, got.z, got.c, got.b, exp);
        end
    endtask

    task automatic check_addr(input logic [15:0] got, input logic [15:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %04h, expected %04h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Status byte as PHP pushes it after an ASL from a zeroed status
    function automatic status_t expected_push(input logic [7:0] res, input logic carry);
        status_t s;
        s   = '0;
        s.n = res[7];
        s.z = (res == 8'h00);
        s.c = carry;
        s.b = 1'b1;
        return s;
    endfunction

    // Bus monitor sampled just before each rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            held = 1'b0;
        end else begin
            if (held) begin
                check_addr(addr, held_addr, "address held in a stall");
                check_flag(rw, held_rw, "rw held in a stall");
                check_byte(data_out, held_data, "data_out held in a stall");
            end
            if (rdy) begin
                if (bus_cycles == 0) begin
                    first_addr = addr;
                    first_rw   = rw;
                end
                bus_cycles = bus_cycles + 1;
                if (!rw) begin
                    writes = writes + 1;
                end
            end
            held      = !rdy;
            held_addr = addr;
            held_rw   = rw;
            held_data = data_out;
        end
    end

    task automatic start_reset();
        rst_n = 1'b0;
        rdy   = 1'b1;
        u_mem.clear();
        repeat (RESET_CYCLES) @(negedge clk);
    endtask

    // Releases reset and runs until the budget of rdy-high cycles is used up
    task automatic run_program(input int budget, input logic stall);
        int done;
        int low_run;
        done       = 0;
        low_run    = 0;
        bus_cycles = 0;
        writes     = 0;
        rst_n      = 1'b1;
        while (done < budget) begin
            if (stall && low_run < 2 && $urandom % 2 == 0) begin
                rdy     = 1'b0;
                low_run = low_run + 1;
            end else begin
                rdy     = 1'b1;
                low_run = 0;
                done    = done + 1;
            end
            @(negedge clk);
        end
        rdy = 1'b1;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%-20s passed", name);
        end else begin
            $display("%-20s failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_reset_state();
        int err_before;
        err_before = errors;
        start_reset();
        u_mem.write_byte(16'h0050, 8'hA5);          // Must be overwritten by the reset A
        u_mem.write_byte(RESET_PC,         OP_NOP);
        u_mem.write_byte(RESET_PC + 16'd1, OP_STA_ZPG);
        u_mem.write_byte(RESET_PC + 16'd2, 8'h50);
        run_program(BUDGET_FIRST, 1'b0);
        check_addr(first_addr, RESET_PC, "first bus address");
        check_flag(first_rw, 1'b1, "first bus rw");
        check_byte(u_mem.read_byte(16'h0050), 8'h00, "stored reset A");
        check_count(writes, 1, "write cycles");
        report_test("reset_state", err_before);
    endtask

    task automatic test_shift_accumulator(input logic stall, input string name);
        int         err_before;
        logic [7:0] v;
        logic [7:0] res;
        err_before = errors;
        for (int i = 0; i < NUM_VALUES; i++) begin
            v   = shift_values[i];
            res = v << 1;
            start_reset();
            u_mem.write_byte(RESET_PC,         OP_LDA_IMM);
            u_mem.write_byte(RESET_PC + 16'd1, v);
            u_mem.write_byte(RESET_PC + 16'd2, OP_ASL_A);
            u_mem.write_byte(RESET_PC + 16'd3, OP_STA_ZPG);
            u_mem.write_byte(RESET_PC + 16'd4, STORE_ZP);
            u_mem.write_byte(RESET_PC + 16'd5, OP_PHP);
            run_program(BUDGET_SHIFT_A, stall);
            check_byte(u_mem.read_byte({8'h00, STORE_ZP}), res, "stored A");
            check_status(u_mem.read_byte(PUSH_ADDR), expected_push(res, v[7]), "pushed status");
            check_count(writes, 2, "write cycles");
        end
        report_test(name, err_before);
    endtask

    task automatic test_shift_zero_page();
        int         err_before;
        logic [7:0] w;
        logic [7:0] res;
        err_before = errors;
        w   = 8'($urandom()) | 8'h80;               // Carry out always set
        res = w << 1;
        start_reset();
        u_mem.write_byte({8'h00, SHIFT_ZP}, w);
        u_mem.write_byte(RESET_PC,         OP_ASL_ZPG);
        u_mem.write_byte(RESET_PC + 16'd1, SHIFT_ZP);
        u_mem.write_byte(RESET_PC + 16'd2, OP_PHP);
        run_program(BUDGET_ZPG, 1'b0);
        check_byte(u_mem.read_byte({8'h00, SHIFT_ZP}), res, "shifted zero-page byte");
        check_status(u_mem.read_byte(PUSH_ADDR), expected_push(res, w[7]), "pushed status");
        check_count(writes, 2, "write cycles");
        report_test("shift_zero_page", err_before);
    endtask

    task automatic test_shift_zero_page_x();
        int         err_before;
        logic [7:0] x;
        logic [7:0] target;
        logic [7:0] w;
        err_before = errors;
        x      = 8'(1 + $urandom % 255);
        target = INDEX_ZP + x;                      // Wraps inside page zero
        w      = 8'($urandom());
        start_reset();
        u_mem.write_byte({8'h00, INDEX_ZP}, 8'h5A);
        u_mem.write_byte({8'h00, target}, w);
        u_mem.write_byte(RESET_PC,         OP_LDX_IMM);
        u_mem.write_byte(RESET_PC + 16'd1, x);
        u_mem.write_byte(RESET_PC + 16'd2, OP_ASL_ZPG_X);
        u_mem.write_byte(RESET_PC + 16'd3, INDEX_ZP);
        run_program(BUDGET_ZPG_X, 1'b0);
        check_byte(u_mem.read_byte({8'h00, target}), w << 1, "shifted indexed byte");
        check_byte(u_mem.read_byte({8'h00, INDEX_ZP}), 8'h5A, "unindexed neighbour");
        check_count(writes, 1, "write cycles");
        report_test("shift_zero_page_x", err_before);
    endtask

    task automatic test_shift_absolute();
        int         err_before;
        logic [7:0] w;
        err_before = errors;
        w = 8'($urandom());
        start_reset();
        u_mem.write_byte(ABS_ADDR, w);
        u_mem.write_byte({8'h00, ABS_ADDR[7:0]}, 8'hC3);   // Zero-page alias stays put
        u_mem.write_byte(RESET_PC,         OP_ASL_ABS);
        u_mem.write_byte(RESET_PC + 16'd1, ABS_ADDR[7:0]);
        u_mem.write_byte(RESET_PC + 16'd2, ABS_ADDR[15:8]);
        run_program(BUDGET_ABS, 1'b0);
        check_byte(u_mem.read_byte(ABS_ADDR), w << 1, "shifted absolute byte");
        check_byte(u_mem.read_byte({8'h00, ABS_ADDR[7:0]}), 8'hC3, "zero-page alias");
        check_count(writes, 1, "write cycles");
        report_test("shift_absolute", err_before);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        rdy        = 1'b1;
        checks     = 0;
        errors     = 0;
        tests      = 0;
        bus_cycles = 0;
        writes     = 0;
        held       = 1'b0;
        first_addr = '0;
        first_rw   = 1'b0;
        void'($urandom(16));
        shift_values[0] = 8'h80;                    // Shifts to zero with carry
        for (int i = 1; i < NUM_VALUES; i++) begin
            shift_values[i] = 8'($urandom());
        end
        test_reset_state();
        test_shift_accumulator(1'b0, "shift_accumulator");
        test_shift_zero_page();
        test_shift_zero_page_x();
        test_shift_absolute();
        test_shift_accumulator(1'b1, "shift_with_stalls");  // Same values as above
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles",
                 TOTAL_CYCLES + MARGIN_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/address_unit.sv
verilog/instruction_decode.sv
verilog/cpu_core.sv
test/sim_memory.sv
test/tb_cpu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log for failure
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cpu_core -f filelist.f \
    && ./obj_dir/Vtb_cpu_core | tee sim.log \
    && ! grep -q "Test FAILED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
